/* source/addr_pkg.sv */
////////////////////
// address path widths and cycle kinds, shared by the RTL and the testbench
// the extension byte sits directly above the internal bus in the register
// so a change to either width moves the extension field with it
////////////////////

package addr_pkg;

   ////////////////////
   // widths
   ////////////////////

   // full address register and external address bus
   localparam int AR_WIDTH = 24;

   // internal processor bus, loaded into the low part of the register
   localparam int IBUS_WIDTH = 16;

   // address extension byte, loaded into the top of the register
   localparam int AEXT_WIDTH = 8;

   // front panel data bus, which only ever carries the top address byte
   localparam int FPD_WIDTH = 8;

   ////////////////////
   // types
   ////////////////////

   // one full address, used for the register and for the address bus
   typedef logic [AR_WIDTH-1:0] ar_t;

   // the kind of external cycle, which picks the strobe that goes low
   typedef enum logic {
      CYCLE_MEM = 1'b0,
      CYCLE_IO  = 1'b1
   } cycle_kind_t;

endpackage

/* source/iomap_pkg.sv */
////////////////////
// I/O map of the address decoder
// with full decode off, bits 15:10 are ignored and I/O space repeats
// every 1,024 addresses
////////////////////

package iomap_pkg;

   ////////////////////
   // decoded address bits
   ////////////////////

   // bits 9:8 choose one of four groups of 256 addresses
   localparam int IO_SEL_LSB = 8;
   localparam int IO_SEL_MSB = 9;

   // lowest of the upper bits that must all be zero under full decode
   localparam int IO_HIGH_LSB = 10;

   // set to 0 for partial decode, which saves the compare on the upper bits
   localparam bit IO_FULL_DECODE = 1'b1;

   ////////////////////
   // select lines
   ////////////////////

   // one select per group
   localparam int IO_NSEL = 4;

   // group index of each device-select line
   localparam int IO_IDX_SYSDEV = 0;
   localparam int IO_IDX_DEV1XX = 1;
   localparam int IO_IDX_DEV2XX = 2;
   localparam int IO_IDX_DEV3XX = 3;

endpackage

/* source/address_register.sv */
////////////////////
// 24-bit address register with a one-cycle load and the front panel readout
// loads are ignored while hold is high, so the address stays put under a cycle
////////////////////

`timescale 1ns/1ns

module address_register (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             write_ar,
   input  logic [addr_pkg::IBUS_WIDTH-1:0]  ibus,
   input  logic [addr_pkg::AEXT_WIDTH-1:0]  aext,
   input  logic                             hold,
   input  logic                             nfparh,
   output addr_pkg::ar_t                    ar,
   output logic [addr_pkg::FPD_WIDTH-1:0]   fpd
);

   import addr_pkg::*;

   ////////////////////
   // load control
   ////////////////////

   // a load is taken only when the bus cycle controller is idle
   logic load_en;

   // top byte of the register, which is all the front panel needs to be told
   logic [FPD_WIDTH-1:0] ar_high;

   assign load_en = write_ar && !hold;

   ////////////////////
   // register
   ////////////////////

   // the extension byte goes on top and the internal bus fills the rest
   // so the new address is visible one edge after the strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ar <= '0;
      end else if (load_en) begin
         ar <= {aext, ibus};
      end
   end

   ////////////////////
   // front panel readout
   ////////////////////

   // the panel can already watch the low bits on the address bus during a
   // cycle, so only the top byte is buffered out for it
   assign ar_high = ar[AR_WIDTH-1 -: FPD_WIDTH];

   // the buffer is enabled by the active-low read line and reads as zero
   // when it is not enabled, since there is no tri-state here
   always_comb begin
      if (!nfparh) begin
         fpd = ar_high;
      end else begin
         fpd = '0;
      end
   end

endmodule

/* source/io_decoder.sv */
////////////////////
// I/O device-select decoder, combinational from the address register
// selects follow nio in the same cycle and at most one is low at a time
////////////////////

`timescale 1ns/1ns

module io_decoder (
   input  addr_pkg::ar_t ar,
   input  logic          nio,
   output logic          nsysdev,
   output logic          niodev1xx,
   output logic          niodev2xx,
   output logic          niodev3xx
);

   import addr_pkg::*;
   import iomap_pkg::*;

   // group number taken from bits 9:8 of the latched address
   logic [IO_SEL_MSB-IO_SEL_LSB:0] grp;

   // high when bits 15:10 are all zero
   logic high_zero;

   // high when one select should be driven low this cycle
   logic sel_en;

   // active-low select vector, indexed by group
   logic [IO_NSEL-1:0] nsel;

   ////////////////////
   // decode
   ////////////////////

   // decoding from the register instead of the address bus lets the select
   // go low as soon as nio does, with no wait for the bus to settle
   assign grp       = ar[IO_SEL_MSB:IO_SEL_LSB];
   assign high_zero = (ar[IBUS_WIDTH-1:IO_HIGH_LSB] == '0);

   // under partial decode the upper bits are don't-care
   assign sel_en = !nio && (high_zero || !IO_FULL_DECODE);

   always_comb begin
      nsel = '1;
      if (sel_en) begin
         nsel[grp] = 1'b0;
      end
   end

   ////////////////////
   // select lines
   ////////////////////

   // group 0 holds the system devices, the rest are free for expansion
   assign nsysdev   = nsel[IO_IDX_SYSDEV];
   assign niodev1xx = nsel[IO_IDX_DEV1XX];
   assign niodev2xx = nsel[IO_IDX_DEV2XX];
   assign niodev3xx = nsel[IO_IDX_DEV3XX];

endmodule

/* source/bus_cycle_ctrl.sv */
////////////////////
// runs one memory or I/O cycle over a four-phase req/ack handshake
// a start while busy is dropped, and the target must drop ack before the end
// the address bus reads as zero whenever no strobe is low
////////////////////

`timescale 1ns/1ns

module bus_cycle_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cycle_start,
   input  addr_pkg::cycle_kind_t cycle_kind,
   input  logic                  ack,
   input  addr_pkg::ar_t         ar,
   output logic                  busy,
   output logic                  cycle_done,
   output logic                  req,
   output logic                  nmem,
   output logic                  nio,
   output addr_pkg::ar_t         ab
);

   import addr_pkg::*;

   ////////////////////
   // state
   ////////////////////

   // idle, then waiting for ack to rise, then waiting for it to fall again
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_WAIT_HI = 2'd1,
      ST_WAIT_LO = 2'd2
   } state_t;

   state_t state;
   state_t state_nxt;

   // kind of the open cycle, held so the strobe cannot change mid-cycle
   cycle_kind_t kind_q;

   // a new cycle is taken only from idle
   logic start_ok;

   // the cycle ends on the edge where ack is seen low again
   logic finish;

   // high while either strobe is low, and then the address bus is driven
   logic ab_en;

   assign start_ok = cycle_start && (state == ST_IDLE);
   assign finish   = (state == ST_WAIT_LO) && !ack;

   ////////////////////
   // next state
   ////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (cycle_start) begin
               state_nxt = ST_WAIT_HI;
            end
         end
         ST_WAIT_HI: begin
            // req drops on the edge after ack is seen high
            if (ack) begin
               state_nxt = ST_WAIT_LO;
            end
         end
         ST_WAIT_LO: begin
            if (!ack) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         kind_q     <= CYCLE_MEM;
         cycle_done <= 1'b0;
      end else begin
         state      <= state_nxt;
         // one-cycle pulse after the last handshake phase
         cycle_done <= finish;
         if (start_ok) begin
            kind_q <= cycle_kind;
         end
      end
   end

   ////////////////////
   // outputs
   ////////////////////

   // busy spans both wait states, so it covers the whole cycle
   assign busy = (state != ST_IDLE);

   // req is only high before the target has answered
   assign req = (state == ST_WAIT_HI);

   // exactly one strobe is low for the whole open cycle
   assign nmem = !(busy && (kind_q == CYCLE_MEM));
   assign nio  = !(busy && (kind_q == CYCLE_IO));

   // enable formed from both active-low strobes
   assign ab_en = !(nmem && nio);
   assign ab    = ab_en ? ar : '0;

endmodule

/* source/addr_unit.sv */
////////////////////
// address unit top, joining the address register, the I/O decoder and the
// bus cycle controller
////////////////////

`timescale 1ns/1ns

module addr_unit (
   input  logic                             clk,
   input  logic                             rst_n,
   // processor side
   input  logic                             write_ar,
   input  logic [addr_pkg::IBUS_WIDTH-1:0]  ibus,
   input  logic [addr_pkg::AEXT_WIDTH-1:0]  aext,
   input  logic                             cycle_start,
   input  addr_pkg::cycle_kind_t            cycle_kind,
   input  logic                             nfparh,
   output logic                             busy,
   output logic                             cycle_done,
   // external side
   output addr_pkg::ar_t                    ab,
   output logic                             nmem,
   output logic                             nio,
   output logic                             req,
   input  logic                             ack,
   output logic                             nsysdev,
   output logic                             niodev1xx,
   output logic                             niodev2xx,
   output logic                             niodev3xx,
   output logic [addr_pkg::FPD_WIDTH-1:0]   fpd
);

   import addr_pkg::*;

   // latched address, shared by the controller and the decoder
   ar_t ar;

   // busy holds the register, so the address cannot change under a cycle
   address_register u_ar (
      .clk      (clk),
      .rst_n    (rst_n),
      .write_ar (write_ar),
      .ibus     (ibus),
      .aext     (aext),
      .hold     (busy),
      .nfparh   (nfparh),
      .ar       (ar),
      .fpd      (fpd)
   );

   // the decoder watches the register directly and takes nio for timing
   io_decoder u_iodec (
      .ar        (ar),
      .nio       (nio),
      .nsysdev   (nsysdev),
      .niodev1xx (niodev1xx),
      .niodev2xx (niodev2xx),
      .niodev3xx (niodev3xx)
   );

   bus_cycle_ctrl u_bcc (
      .clk         (clk),
      .rst_n       (rst_n),
      .cycle_start (cycle_start),
      .cycle_kind  (cycle_kind),
      .ack         (ack),
      .ar          (ar),
      .busy        (busy),
      .cycle_done  (cycle_done),
      .req         (req),
      .nmem        (nmem),
      .nio         (nio),
      .ab          (ab)
   );

endmodule

/* tests/tb_addr_unit.sv */
////////////////////
// table-driven testbench for the address unit, with a four-phase target model
// ack delays of 0 to 3 cycles come from a fixed-seed xorshift generator
////////////////////

`timescale 1ns/1ns

module tb_addr_unit;

   import addr_pkg::*;
   import iomap_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int RST_CYCLES  = 2;
   localparam int NROWS       = 9;
   localparam int CYCLE_LIMIT = 16;
   localparam logic [31:0] SEED = 32'h7e53_5a8c;
   // every row fits in 20 clock cycles and the reset phase gets a few more
   localparam int WATCHDOG_NS = (NROWS * 20 + RST_CYCLES + 4) * CLK_PERIOD;

   // one table row whose nfparh is driven as given while the row runs
   typedef struct packed {
      logic [IBUS_WIDTH-1:0] ibus;
      logic [AEXT_WIDTH-1:0] aext;
      cycle_kind_t           kind;
      logic                  nfparh;
   } row_t;

   localparam row_t ROWS [NROWS] = '{
      '{16'h1234, 8'ha5, CYCLE_MEM, 1'b0},
      '{16'h0012, 8'h3c, CYCLE_IO,  1'b1},
      '{16'h0145, 8'h00, CYCLE_IO,  1'b0},
      '{16'h02ff, 8'h7e, CYCLE_IO,  1'b1},
      '{16'h0300, 8'hc3, CYCLE_IO,  1'b0},
      '{16'h0700, 8'h11, CYCLE_IO,  1'b1},
      '{16'hfd01, 8'h80, CYCLE_IO,  1'b0},
      '{16'hffff, 8'hff, CYCLE_MEM, 1'b0},
      '{16'h0000, 8'h01, CYCLE_MEM, 1'b1}
   };

   logic clk;
   logic rst_n, write_ar, cycle_start, nfparh, ack;
   logic [IBUS_WIDTH-1:0] ibus;
   logic [AEXT_WIDTH-1:0] aext;
   cycle_kind_t cycle_kind;
   logic busy, cycle_done, nmem, nio, req;
   logic nsysdev, niodev1xx, niodev2xx, niodev3xx;
   ar_t ab;
   logic [FPD_WIDTH-1:0] fpd;
   // select lines gathered by group index
   logic [IO_NSEL-1:0] nsel_seen;
   int value_errors = 0;
   int proto_errors = 0;
   int stall_errors = 0;
   int done_count = 0;

   assign nsel_seen[IO_IDX_SYSDEV] = nsysdev;
   assign nsel_seen[IO_IDX_DEV1XX] = niodev1xx;
   assign nsel_seen[IO_IDX_DEV2XX] = niodev2xx;
   assign nsel_seen[IO_IDX_DEV3XX] = niodev3xx;

   addr_unit UUT (
      .clk(clk), .rst_n(rst_n), .write_ar(write_ar), .ibus(ibus), .aext(aext),
      .cycle_start(cycle_start), .cycle_kind(cycle_kind), .nfparh(nfparh),
      .busy(busy), .cycle_done(cycle_done), .ab(ab), .nmem(nmem), .nio(nio),
      .req(req), .ack(ack), .nsysdev(nsysdev), .niodev1xx(niodev1xx),
      .niodev2xx(niodev2xx), .niodev3xx(niodev3xx), .fpd(fpd)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // one select per group of 256 and the upper bits must be clear under full decode
   function automatic logic [IO_NSEL-1:0] expected_selects(input row_t r);
      logic [IO_NSEL-1:0] nsel;
      logic upper_clear;
      nsel = '1;
      upper_clear = (r.ibus[IBUS_WIDTH-1:IO_HIGH_LSB] == '0);
      if (r.kind == CYCLE_IO && (upper_clear || !IO_FULL_DECODE)) begin
         nsel[r.ibus[IO_SEL_MSB:IO_SEL_LSB]] = 1'b0;
      end
      return nsel;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         value_errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // outputs with no cycle open
   task automatic check_idle();
      check_val("req", 32'(req), 32'd0);
      check_val("busy", 32'(busy), 32'd0);
      check_val("nmem", 32'(nmem), 32'd1);
      check_val("nio", 32'(nio), 32'd1);
      check_val("selects", 32'(nsel_seen), 32'hf);
      check_val("ab", 32'(ab), 32'd0);
   endtask

   task automatic run_row(input int idx, input row_t r);
      ar_t exp_ab;
      logic [IO_NSEL-1:0] exp_nsel;
      logic [FPD_WIDTH-1:0] exp_fpd;
      int n;
      exp_ab = {r.aext, r.ibus};
      exp_nsel = expected_selects(r);
      exp_fpd = r.nfparh ? '0 : r.aext;
      n = 0;
      @(posedge clk);
      ibus <= r.ibus;
      aext <= r.aext;
      nfparh <= r.nfparh;
      write_ar <= 1'b1;
      @(posedge clk);
      write_ar <= 1'b0;
      @(negedge clk);
      check_val("fpd", 32'(fpd), 32'(exp_fpd));
      check_idle();
      @(posedge clk);
      cycle_start <= 1'b1;
      cycle_kind <= r.kind;
      // the start is taken at this edge, so the next load and start hit a busy unit
      // the dropped start asks for the other kind, which must not reach the strobes
      @(posedge clk);
      write_ar <= 1'b1;
      ibus <= ~r.ibus;
      aext <= ~r.aext;
      cycle_kind <= (r.kind == CYCLE_MEM) ? CYCLE_IO : CYCLE_MEM;
      @(posedge clk);
      cycle_start <= 1'b0;
      write_ar <= 1'b0;
      @(negedge clk);
      while (!cycle_done && n < CYCLE_LIMIT) begin
         check_val("busy", 32'(busy), 32'd1);
         check_val("ab", 32'(ab), 32'(exp_ab));
         check_val("nmem", 32'(nmem), 32'(r.kind == CYCLE_IO));
         check_val("nio", 32'(nio), 32'(r.kind == CYCLE_MEM));
         check_val("selects", 32'(nsel_seen), 32'(exp_nsel));
         n++;
         @(negedge clk);
      end
      assert (cycle_done) else begin
         stall_errors++;
         $display("row %0d: the cycle did not end within %0d clocks", idx, CYCLE_LIMIT);
      end
      check_idle();
      @(negedge clk);
      // expect a single done pulse and no new cycle from the dropped start
      check_val("cycle_done", 32'(cycle_done), 32'd0);
      check_idle();
      check_val("fpd", 32'(fpd), 32'(exp_fpd));
   endtask

   ////////////////////
   // target model
   ////////////////////

   // follows req after a random delay, one phase at a time
   initial begin : target_model
      logic [31:0] rng;
      logic [1:0] wait_cnt;
      ack <= 1'b0;
      rng = SEED;
      wait_cnt = 2'd0;
      forever begin
         @(posedge clk);
         if (!rst_n) begin
            ack <= 1'b0;
         end else if (req != ack) begin
            if (wait_cnt == 2'd0) begin
               ack <= req;
               rng = next_rand(rng);
               wait_cnt = rng[1:0];
            end else begin
               wait_cnt = wait_cnt - 2'd1;
            end
         end
      end
   end

   ////////////////////
   // handshake monitor
   ////////////////////

   initial begin : handshake_monitor
      logic req_q;
      logic ack_q;
      logic ack_seen;
      req_q = 1'b0;
      ack_q = 1'b0;
      ack_seen = 1'b0;
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (req && !req_q) begin
               assert (!ack) else begin
                  proto_errors++;
                  $display("req rose while ack was still high");
               end
            end
            assert (!(req && ack_q)) else begin
               proto_errors++;
               $display("req stayed high after ack was seen high");
            end
            if (cycle_done) begin
               done_count++;
               assert (ack_seen && !ack) else begin
                  proto_errors++;
                  $display("cycle_done came before ack had risen and fallen");
               end
            end
            if (req || !nmem || !nio) begin
               assert (busy) else begin
                  proto_errors++;
                  $display("busy was low while a cycle was open");
               end
            end
            // ack_seen tracks the answer of the cycle now open
            if (cycle_done) begin
               ack_seen = 1'b0;
            end else if (ack) begin
               ack_seen = 1'b1;
            end
         end
         req_q = req;
         ack_q = ack;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the test did not reach its end in time");
      $display("Verification failed");
      $finish;
   end

   initial begin
      rst_n <= 1'b0;
      write_ar <= 1'b0;
      ibus <= '0;
      aext <= '0;
      cycle_start <= 1'b0;
      cycle_kind <= CYCLE_MEM;
      // the panel reads through reset, so fpd shows the cleared register top byte
      nfparh <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_idle();
      check_val("cycle_done", 32'(cycle_done), 32'd0);
      check_val("fpd", 32'(fpd), 32'd0);
      for (int i = 0; i < NROWS; i++) begin
         run_row(i, ROWS[i]);
      end
      check_val("done_count", 32'(done_count), 32'(NROWS));
      $display("errors: value %0d, protocol %0d, timeout %0d",
               value_errors, proto_errors, stall_errors);
      if (value_errors + proto_errors + stall_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* project.f */
source/addr_pkg.sv
source/iomap_pkg.sv
source/address_register.sv
source/io_decoder.sv
source/bus_cycle_ctrl.sv
source/addr_unit.sv
tests/tb_addr_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the address unit testbench with Verilator and runs it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f project.f \
   --top-module tb_addr_unit -o tb_addr_unit > "$BUILD_LOG" 2>&1 \
   && ./obj_dir/tb_addr_unit > "$SIM_LOG" 2>&1 \
   || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$SIM_LOG"

grep -q "^Verification passed$" "$SIM_LOG" \
   && { echo "simulation PASS"; exit 0; } \
   || { echo "simulation FAIL"; exit 1; }
